/* Makefile */
# Verilator build and run of the I/O access unit testbench
VERILATOR ?= verilator
TOP       ?= tb_io_access_unit
FLAGS     ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f

.PHONY: sim clean

# The run passes only when the pass line appears in the simulator output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* hw/io_access_if.sv */
/*
 * Operand class, port index and selected Empty/Full bits shared by the
 * decoder, the port flags and the ready logic.
 */
`timescale 1ns/1ns

interface io_access_if;
    import io_pkg::*;

    // Driven by the decoder
    logic  a_rd_is_io, b_rd_is_io, a_wr_is_io, b_wr_is_io;
    port_t a_rd_port,  b_rd_port,  a_wr_port,  b_wr_port;

    // Flag bit of each operand's port, driven by the flag block
    logic  a_rd_ef, b_rd_ef, a_wr_ef, b_wr_ef;

    modport decoder (output a_rd_is_io, b_rd_is_io, a_wr_is_io, b_wr_is_io,
                     output a_rd_port, b_rd_port, a_wr_port, b_wr_port);

    modport flags   (input  a_rd_is_io, b_rd_is_io, a_wr_is_io, b_wr_is_io,
                     input  a_rd_port, b_rd_port, a_wr_port, b_wr_port,
                     output a_rd_ef, b_rd_ef, a_wr_ef, b_wr_ef);

    modport ready   (input  a_rd_is_io, b_rd_is_io, a_wr_is_io, b_wr_is_io,
                     input  a_rd_ef, b_rd_ef, a_wr_ef, b_wr_ef);

endinterface

/* hw/io_access_unit.sv */
/*
 * I/O gate of the soft processor. Decides accept or retry for each issued
 * instruction and keeps the port flags, with plain ports to the outside.
 */
`timescale 1ns/1ns

module io_access_unit (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic                         issue,
    input  io_pkg::addr_t                a_rd_addr,
    input  io_pkg::addr_t                b_rd_addr,
    input  io_pkg::addr_t                a_wr_addr,
    input  io_pkg::addr_t                b_wr_addr,
    input  logic                         cfg_we,
    input  logic                         cfg_sel,
    input  io_pkg::addr_t                cfg_data,
    input  logic [io_pkg::NUM_PORTS-1:0] rd_push,
    input  logic [io_pkg::NUM_PORTS-1:0] wr_pop,
    output logic                         accept,
    output logic                         retry,
    output logic [io_pkg::NUM_PORTS-1:0] rd_full,
    output logic [io_pkg::NUM_PORTS-1:0] wr_full
);
    import io_pkg::*;

    addr_t io_base, io_mask;
    addr_t a_rd_addr_q, b_rd_addr_q, a_wr_addr_q, b_wr_addr_q;
    logic  all_io_ready;
    logic  commit;

    io_access_if acc ();

    io_window_regs u_window (
        .clock, .arst_n, .cfg_we, .cfg_sel, .cfg_data, .io_base, .io_mask
    );

    io_issue_stage u_issue (
        .clock, .arst_n, .issue,
        .a_rd_addr, .b_rd_addr, .a_wr_addr, .b_wr_addr,
        .a_rd_addr_q, .b_rd_addr_q, .a_wr_addr_q, .b_wr_addr_q,
        .all_io_ready, .commit, .accept, .retry
    );

    // The decoder works on the held instruction, not on the live inputs
    io_addr_decoder u_decoder (
        .io_base, .io_mask,
        .a_rd_addr (a_rd_addr_q),
        .b_rd_addr (b_rd_addr_q),
        .a_wr_addr (a_wr_addr_q),
        .b_wr_addr (b_wr_addr_q),
        .acc       (acc.decoder)
    );

    io_port_flags u_flags (
        .clock, .arst_n, .acc (acc.flags), .commit, .rd_push, .wr_pop, .rd_full, .wr_full
    );

    io_ready #(.REGISTERED(1'b0)) u_ready (
        .clock, .acc (acc.ready), .all_io_ready
    );

endmodule

/* hw/io_addr_decoder.sv */
/*
 * Classifies the four operand addresses as I/O or memory against the window
 * and extracts their port indices. Purely combinational.
 */
`timescale 1ns/1ns

module io_addr_decoder (
    input  io_pkg::addr_t      io_base,
    input  io_pkg::addr_t      io_mask,
    input  io_pkg::addr_t      a_rd_addr,
    input  io_pkg::addr_t      b_rd_addr,
    input  io_pkg::addr_t      a_wr_addr,
    input  io_pkg::addr_t      b_wr_addr,
    io_access_if.decoder       acc
);
    import io_pkg::*;

    // An address is I/O when the bits kept by the mask match the base
    function automatic logic in_window(addr_t addr);
        return (addr & io_mask) == (io_base & io_mask);
    endfunction

    always_comb begin
        acc.a_rd_is_io = in_window(a_rd_addr);
        acc.b_rd_is_io = in_window(b_rd_addr);
        acc.a_wr_is_io = in_window(a_wr_addr);
        acc.b_wr_is_io = in_window(b_wr_addr);
    end

    // The index is meaningful only when the matching class bit is set
    always_comb begin
        acc.a_rd_port = a_rd_addr[PORT_W-1:0];
        acc.b_rd_port = b_rd_addr[PORT_W-1:0];
        acc.a_wr_port = a_wr_addr[PORT_W-1:0];
        acc.b_wr_port = b_wr_addr[PORT_W-1:0];
    end

endmodule

/* hw/io_issue_stage.sv */
/*
 * Holds the issued instruction for one cycle and decides it. Commit is the
 * combinational decision; accept and retry are its registered outcome.
 */
`timescale 1ns/1ns

module io_issue_stage (
    input  logic          clock,
    input  logic          arst_n,
    input  logic          issue,
    input  io_pkg::addr_t a_rd_addr,
    input  io_pkg::addr_t b_rd_addr,
    input  io_pkg::addr_t a_wr_addr,
    input  io_pkg::addr_t b_wr_addr,
    output io_pkg::addr_t a_rd_addr_q,
    output io_pkg::addr_t b_rd_addr_q,
    output io_pkg::addr_t a_wr_addr_q,
    output io_pkg::addr_t b_wr_addr_q,
    input  logic          all_io_ready,
    output logic          commit,
    output logic          accept,
    output logic          retry
);
    logic valid;  // An instruction is waiting for its decision

    always_ff @(posedge clock) begin
        if (issue) begin
            a_rd_addr_q <= a_rd_addr;
            b_rd_addr_q <= b_rd_addr;
            a_wr_addr_q <= a_wr_addr;
            b_wr_addr_q <= b_wr_addr;
        end
    end

    assign commit = valid && all_io_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid  <= 1'b0;
            accept <= 1'b0;
            retry  <= 1'b0;
        end else begin
            valid  <= issue;
            accept <= commit;  // Rises at the same edge that updates the flags
            retry  <= valid && !all_io_ready;
        end
    end

    // An unknown ready level would leave accept and retry both undefined
    a_ready_known: assert property (
        @(posedge clock) disable iff (!arst_n)
        valid |-> !$isunknown(all_io_ready)
    );

endmodule

/* hw/io_pkg.sv */
/*
 * Shared widths, port count, flag polarities and window reset values for the
 * I/O access unit. Modules pull these in with a wildcard import.
 */
package io_pkg;

    localparam int ADDR_W    = 10;  // Operand address width
    localparam int NUM_PORTS = 4;   // Read ports, and as many write ports
    localparam int PORT_W    = 2;   // Port index, taken from the low address bits

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [PORT_W-1:0] port_t;

    // A flag bit is set while its port holds a word
    localparam logic EF_FULL  = 1'b1;
    localparam logic EF_EMPTY = 1'b0;

    // Window after reset covers 0x3F0..0x3F3, one address per port
    localparam addr_t IO_BASE_RESET = 10'h3F0;
    localparam addr_t IO_MASK_RESET = 10'h3FC;

    // Register selectors of the window block
    localparam logic CFG_BASE = 1'b0;
    localparam logic CFG_MASK = 1'b1;

endpackage

/* hw/io_port_flags.sv */
/*
 * Empty/Full flags of the read and write ports. Presents the bit of each
 * operand's port and updates the flags on commit, push and pop.
 */
`timescale 1ns/1ns

module io_port_flags (
    input  logic                         clock,
    input  logic                         arst_n,
    io_access_if.flags                   acc,
    input  logic                         commit,
    input  logic [io_pkg::NUM_PORTS-1:0] rd_push,
    input  logic [io_pkg::NUM_PORTS-1:0] wr_pop,
    output logic [io_pkg::NUM_PORTS-1:0] rd_full,
    output logic [io_pkg::NUM_PORTS-1:0] wr_full
);
    import io_pkg::*;

    logic [NUM_PORTS-1:0] rd_flags;
    logic [NUM_PORTS-1:0] wr_flags;
    logic [NUM_PORTS-1:0] rd_used;    // Read ports named by I/O read operands
    logic [NUM_PORTS-1:0] wr_used;
    logic [NUM_PORTS-1:0] rd_take;
    logic [NUM_PORTS-1:0] wr_fill;

    always_comb begin
        acc.a_rd_ef = rd_flags[acc.a_rd_port];
        acc.b_rd_ef = rd_flags[acc.b_rd_port];
        acc.a_wr_ef = wr_flags[acc.a_wr_port];
        acc.b_wr_ef = wr_flags[acc.b_wr_port];
    end

    // A and B on the same port set the same bit, so the port changes once
    always_comb begin
        rd_used = '0;
        wr_used = '0;
        if (acc.a_rd_is_io) begin
            rd_used[acc.a_rd_port] = 1'b1;
        end
        if (acc.b_rd_is_io) begin
            rd_used[acc.b_rd_port] = 1'b1;
        end
        if (acc.a_wr_is_io) begin
            wr_used[acc.a_wr_port] = 1'b1;
        end
        if (acc.b_wr_is_io) begin
            wr_used[acc.b_wr_port] = 1'b1;
        end
        rd_take = rd_used & {NUM_PORTS{commit}};
        wr_fill = wr_used & {NUM_PORTS{commit}};
    end

    // Push and pop are applied last so they win over the commit effect
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_flags <= {NUM_PORTS{EF_EMPTY}};
            wr_flags <= {NUM_PORTS{EF_EMPTY}};
        end else begin
            rd_flags <= (rd_flags & ~rd_take) | rd_push;
            wr_flags <= (wr_flags | wr_fill) & ~wr_pop;
        end
    end

    assign rd_full = rd_flags;
    assign wr_full = wr_flags;

    // The issue stage must only commit when every used port is ready
    a_commit_ready: assert property (
        @(posedge clock) disable iff (!arst_n)
        commit |-> ((rd_used & ~rd_flags) == '0) && ((wr_used & wr_flags) == '0)
    );

endmodule

/* hw/io_ready.sv */
/*
 * Combines the Empty/Full bits of the current operands into one ready level.
 * Memory operands never hold an instruction back.
 */
`timescale 1ns/1ns

module io_ready #(
    parameter bit REGISTERED = 1'b0
) (
    input  logic        clock,
    io_access_if.ready  acc,
    output logic        all_io_ready
);
    import io_pkg::*;

    logic a_rd_ef_masked;
    logic b_rd_ef_masked;
    logic a_wr_ef_masked;
    logic b_wr_ef_masked;
    logic all_reads_ready;
    logic all_writes_ready;
    logic ready_now;

    // Non-I/O reads look Full and non-I/O writes look Empty
    always_comb begin
        a_rd_ef_masked = acc.a_rd_is_io ? acc.a_rd_ef : EF_FULL;
        b_rd_ef_masked = acc.b_rd_is_io ? acc.b_rd_ef : EF_FULL;
        a_wr_ef_masked = acc.a_wr_is_io ? acc.a_wr_ef : EF_EMPTY;
        b_wr_ef_masked = acc.b_wr_is_io ? acc.b_wr_ef : EF_EMPTY;
    end

    always_comb begin
        all_reads_ready  = (a_rd_ef_masked == EF_FULL)  && (b_rd_ef_masked == EF_FULL);
        all_writes_ready = (a_wr_ef_masked == EF_EMPTY) && (b_wr_ef_masked == EF_EMPTY);
        ready_now        = all_reads_ready && all_writes_ready;
    end

    generate
        if (REGISTERED) begin : g_reg
            // Adds one cycle, so the caller must decide an edge later
            always_ff @(posedge clock) begin
                all_io_ready <= ready_now;
            end
        end else begin : g_comb
            assign all_io_ready = ready_now;
        end
    endgenerate

endmodule

/* hw/io_window_regs.sv */
/*
 * Base and mask of the I/O window, loaded from cfg_data by a write strobe.
 * A write is visible to the decoder right after the edge that takes it.
 */
`timescale 1ns/1ns

module io_window_regs (
    input  logic          clock,
    input  logic          arst_n,
    input  logic          cfg_we,
    input  logic          cfg_sel,
    input  io_pkg::addr_t cfg_data,
    output io_pkg::addr_t io_base,
    output io_pkg::addr_t io_mask
);
    import io_pkg::*;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            io_base <= IO_BASE_RESET;
            io_mask <= IO_MASK_RESET;
        end else if (cfg_we) begin
            if (cfg_sel == CFG_BASE) begin
                io_base <= cfg_data;
            end
            if (cfg_sel == CFG_MASK) begin
                io_mask <= cfg_data;  // Zero bits in the mask widen the window
            end
        end
    end

    // An unknown strobe would leave the window in doubt for every later instruction
    a_cfg_we_known: assert property (
        @(posedge clock) disable iff (!arst_n)
        !$isunknown(cfg_we)
    );

endmodule

/* src.f */
hw/io_pkg.sv
hw/io_access_if.sv
hw/io_window_regs.sv
hw/io_addr_decoder.sv
hw/io_ready.sv
hw/io_port_flags.sv
hw/io_issue_stage.sv
hw/io_access_unit.sv
testbench/tb_io_access_unit.sv

/* testbench/tb_io_access_unit.sv */
/*
 * Self-checking testbench for the I/O access unit. Directed cases cover the
 * port rules and the window, then a random run is compared against a model.
 */
`timescale 1ns/1ns

module tb_io_access_unit;
    import io_pkg::*;

    localparam int OUTCOME_TIMEOUT = 10;   // Cycles allowed for accept or retry
    localparam int RANDOM_CYCLES   = 500;

    logic clock, arst_n, issue, cfg_we, cfg_sel, accept, retry;
    addr_t a_rd_addr, b_rd_addr, a_wr_addr, b_wr_addr, cfg_data;
    logic [NUM_PORTS-1:0] rd_push, wr_pop, rd_full, wr_full;

    // Reference model state, owned by the comparing process
    logic [NUM_PORTS-1:0] m_rd, m_wr;
    addr_t m_base, m_mask, p_ar, p_br, p_aw, p_bw;
    logic p_valid, e_accept, e_retry;

    logic [31:0] lfsr = 32'h1cd9_8cd1;
    string test_name = "reset";
    int check_errors = 0;
    int outcome_errors = 0;
    int timeouts = 0;

    io_access_unit DUT (.*);

    always #20 clock = ~clock;

    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // Taps 32, 22, 2, 1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    // Half the addresses land on the reset window so the ports get exercised
    function automatic addr_t rand_addr();
        addr_t a;
        if (next_bit()) begin
            a = IO_BASE_RESET;
            a[0] = next_bit();
            a[1] = next_bit();
        end else begin
            for (int i = 0; i < ADDR_W; i++) a[i] = next_bit();
        end
        return a;
    endfunction

    function automatic logic [NUM_PORTS-1:0] rand_strobe();
        logic [NUM_PORTS-1:0] s;
        for (int i = 0; i < NUM_PORTS; i++) s[i] = next_bit() & next_bit();  // Sparse strobes
        return s;
    endfunction

    function automatic logic is_io(addr_t addr);
        return ((addr ^ m_base) & m_mask) == '0;
    endfunction

    // Reads need a Full port and writes an Empty one; memory operands always pass
    function automatic logic expect_accept(addr_t ar, addr_t br, addr_t aw, addr_t bw);
        logic ok;
        ok = 1'b1;
        if (is_io(ar) && !m_rd[ar[PORT_W-1:0]]) ok = 1'b0;
        if (is_io(br) && !m_rd[br[PORT_W-1:0]]) ok = 1'b0;
        if (is_io(aw) && m_wr[aw[PORT_W-1:0]]) ok = 1'b0;
        if (is_io(bw) && m_wr[bw[PORT_W-1:0]]) ok = 1'b0;
        return ok;
    endfunction

    task automatic step_model();
        logic ok;
        ok = p_valid && expect_accept(p_ar, p_br, p_aw, p_bw);
        e_accept = ok;
        e_retry = p_valid && !ok;
        if (ok) begin
            if (is_io(p_ar)) m_rd[p_ar[PORT_W-1:0]] = 1'b0;
            if (is_io(p_br)) m_rd[p_br[PORT_W-1:0]] = 1'b0;
            if (is_io(p_aw)) m_wr[p_aw[PORT_W-1:0]] = 1'b1;
            if (is_io(p_bw)) m_wr[p_bw[PORT_W-1:0]] = 1'b1;
        end
        m_rd = m_rd | rd_push;  // Push and pop win over the commit on the same port
        m_wr = m_wr & ~wr_pop;
        if (cfg_we && cfg_sel == CFG_BASE) m_base = cfg_data;
        if (cfg_we && cfg_sel == CFG_MASK) m_mask = cfg_data;
        p_valid = issue;
        p_ar = a_rd_addr;
        p_br = b_rd_addr;
        p_aw = a_wr_addr;
        p_bw = b_wr_addr;
    endtask

    // Model steps on the rising edge, DUT outputs are compared at the falling one
    always begin
        @(posedge clock);
        if (!arst_n) begin
            {m_rd, m_wr, p_valid, e_accept, e_retry} = '0;
            m_base = IO_BASE_RESET;
            m_mask = IO_MASK_RESET;
        end else begin
            step_model();
        end
        @(negedge clock);
        assert (accept == e_accept) else begin
            check_errors++;
            $display("ERR %s: accept expected %0b actual %0b", test_name, e_accept, accept);
        end
        assert (retry == e_retry) else begin
            check_errors++;
            $display("ERR %s: retry expected %0b actual %0b", test_name, e_retry, retry);
        end
        assert (rd_full == m_rd) else begin
            check_errors++;
            $display("ERR %s: rd_full expected %b actual %b", test_name, m_rd, rd_full);
        end
        assert (wr_full == m_wr) else begin
            check_errors++;
            $display("ERR %s: wr_full expected %b actual %b", test_name, m_wr, wr_full);
        end
    end

    // Push and pop go out one cycle after issue, on the edge that decides it
    task automatic run_instr(string name, addr_t ar, addr_t br, addr_t aw, addr_t bw,
                             logic [NUM_PORTS-1:0] push, logic [NUM_PORTS-1:0] pop,
                             logic exp_acc);
        logic done;
        int cycles;
        test_name = name;
        @(negedge clock);
        issue = 1'b1;
        {a_rd_addr, b_rd_addr, a_wr_addr, b_wr_addr} = {ar, br, aw, bw};
        @(negedge clock);
        issue = 1'b0;
        rd_push = push;
        wr_pop = pop;
        done = 1'b0;
        cycles = 0;
        while (!done && cycles < OUTCOME_TIMEOUT) begin
            @(negedge clock);
            rd_push = '0;
            wr_pop = '0;
            cycles++;
            done = accept || retry;
        end
        if (!done) begin
            timeouts++;
            $display("Timeout in %s: neither accept nor retry came back", name);
        end else begin
            assert (accept == exp_acc) else begin
                outcome_errors++;
                $display("ERR %s: accept expected %0b actual %0b", name, exp_acc, accept);
            end
        end
    endtask

    task automatic check_flags(logic [NUM_PORTS-1:0] exp_rd, logic [NUM_PORTS-1:0] exp_wr);
        assert (rd_full == exp_rd && wr_full == exp_wr) else begin
            outcome_errors++;
            $display("ERR %s: flags expected %b/%b actual %b/%b",
                     test_name, exp_rd, exp_wr, rd_full, wr_full);
        end
    endtask

    task automatic pulse_strobes(logic [NUM_PORTS-1:0] push, logic [NUM_PORTS-1:0] pop);
        @(negedge clock);
        rd_push = push;
        wr_pop = pop;
        @(negedge clock);
        rd_push = '0;
        wr_pop = '0;
    endtask

    task automatic config_write(logic sel, addr_t data);
        @(negedge clock);
        {cfg_we, cfg_sel, cfg_data} = {1'b1, sel, data};
        @(negedge clock);
        cfg_we = 1'b0;
    endtask

    initial begin
        {clock, arst_n, issue, cfg_we, cfg_sel, cfg_data, rd_push, wr_pop} = '0;
        {a_rd_addr, b_rd_addr, a_wr_addr, b_wr_addr} = '0;
        repeat (3) @(posedge clock);
        @(negedge clock) arst_n = 1'b1;

        run_instr("memory_only", 10'h010, 10'h020, 10'h030, 10'h040, 4'h0, 4'h0, 1'b1);
        check_flags(4'b0000, 4'b0000);
        run_instr("read_empty", 10'h3F1, 10'h020, 10'h030, 10'h040, 4'h0, 4'h0, 1'b0);
        check_flags(4'b0000, 4'b0000);
        pulse_strobes(4'b0010, 4'b0000);
        run_instr("read_after_push", 10'h3F1, 10'h020, 10'h030, 10'h040, 4'h0, 4'h0, 1'b1);
        check_flags(4'b0000, 4'b0000);

        // Both writes name port 3, so it is filled once
        run_instr("write_same_port", 10'h010, 10'h020, 10'h3F3, 10'h3F3, 4'h0, 4'h0, 1'b1);
        check_flags(4'b0000, 4'b1000);
        run_instr("write_full", 10'h010, 10'h020, 10'h3F3, 10'h040, 4'h0, 4'h0, 1'b0);
        pulse_strobes(4'b0000, 4'b1000);
        run_instr("write_after_pop", 10'h010, 10'h020, 10'h3F3, 10'h040, 4'h0, 4'h0, 1'b1);
        check_flags(4'b0000, 4'b1000);

        pulse_strobes(4'b1111, 4'b0000);
        run_instr("memory_only_flags", 10'h100, 10'h101, 10'h102, 10'h103, 4'h0, 4'h0, 1'b1);
        check_flags(4'b1111, 4'b1000);

        run_instr("window_before", 10'h010, 10'h020, 10'h3F3, 10'h040, 4'h0, 4'h0, 1'b0);
        config_write(CFG_BASE, 10'h200);
        run_instr("window_moved", 10'h010, 10'h020, 10'h3F3, 10'h040, 4'h0, 4'h0, 1'b1);
        check_flags(4'b1111, 4'b1000);
        run_instr("window_new_io", 10'h201, 10'h020, 10'h030, 10'h040, 4'h0, 4'h0, 1'b1);
        check_flags(4'b1101, 4'b1000);
        config_write(CFG_BASE, IO_BASE_RESET);

        // Push on read port 2 and pop on write port 0 land on the commit edge
        run_instr("strobe_override", 10'h3F2, 10'h020, 10'h3F0, 10'h040, 4'b0100, 4'b0001, 1'b1);
        check_flags(4'b1101, 4'b1000);

        test_name = "random_run";
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            @(negedge clock);
            issue = next_bit();
            a_rd_addr = rand_addr();
            b_rd_addr = rand_addr();
            a_wr_addr = rand_addr();
            b_wr_addr = rand_addr();
            rd_push = rand_strobe();
            wr_pop = rand_strobe();
        end
        @(negedge clock);
        {issue, rd_push, wr_pop} = '0;
        repeat (3) @(negedge clock);

        $display("Errors: %0d model mismatches, %0d outcome errors, %0d timeouts",
                 check_errors, outcome_errors, timeouts);
        if (check_errors == 0 && outcome_errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
